//--- Makefile
# Verilator flow for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/fetch_controller.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_controller (
  input  logic                    clock,
  input  logic                    reset,

  // start fetching, looked at only in idle
  input  logic                    fetch_en_i,

  // memory read channel
  output logic                    arvalid_o,
  input  logic                    arready_i,
  input  logic                    rvalid_i,
  output logic                    rready_o,

  // downstream handshake towards decode
  output logic                    valid_o,
  input  logic                    ready_i,

  // back end redirect strobe
  input  logic                    redirect_valid_i,

  // from pre-decode
  input  logic                    is_wait_branch_i,

  // write enables for pc and instruction register
  output logic                    pc_we_o,
  output logic                    redirect_we_o,
  output logic                    inst_we_o,

  // current state, also used for debug
  output fetch_pkg::fetch_state_e state_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // --------------------------------------------------------------------------
  // state decoded outputs
  // --------------------------------------------------------------------------
  assign arvalid_o = (state_q == ST_WAIT_ARREADY);
  assign rready_o  = (state_q == ST_WAIT_RVALID);
  assign valid_o   = (state_q == ST_WAIT_READY);
  assign state_o   = state_q;

  // capture the word on the read handshake
  assign inst_we_o = rready_o && rvalid_i;

  // advance pc on acceptance unless the target is still unknown
  assign pc_we_o = valid_o && ready_i && !is_wait_branch_i;

  // redirect only counts while we are actually waiting for it
  assign redirect_we_o = (state_q == ST_WAIT_BRANCH) && redirect_valid_i;

  // --------------------------------------------------------------------------
  // state register
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fetch_en_i) begin
          state_d = ST_WAIT_ARREADY;
        end
      end
      // address held until the memory takes it
      ST_WAIT_ARREADY: begin
        if (arready_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end
      ST_WAIT_RVALID: begin
        if (rvalid_i) begin
          state_d = ST_WAIT_READY;
        end
      end
      // word on offer to decode
      ST_WAIT_READY: begin
        if (ready_i) begin
          state_d = is_wait_branch_i ? ST_WAIT_BRANCH : ST_WAIT_ARREADY;
        end
      end
      // stalled until the back end resolves the target
      ST_WAIT_BRANCH: begin
        if (redirect_valid_i) begin
          state_d = ST_WAIT_ARREADY;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/fetch_inst_reg.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_inst_reg (
  input  logic             clock,
  input  logic             reset,

  // write strobe on read handshake
  input  logic             inst_we_i,

  // incoming word and the address that fetched it
  input  fetch_pkg::inst_t rdata_i,
  input  fetch_pkg::addr_t pc_i,

  // held pair for decode and pre-decode
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o
);

  import fetch_pkg::*;

  inst_t inst_q;
  addr_t pc_q;

  // word and pc captured together
  // pair stays put while the pc register moves on
  always_ff @(posedge clock) begin
    if (reset) begin
      inst_q <= '0;
      pc_q   <= '0;
    end else if (inst_we_i) begin
      inst_q <= rdata_i;
      pc_q   <= pc_i;
    end
  end

  assign inst_o = inst_q;
  assign pc_o   = pc_q;

endmodule

`default_nettype wire

//--- rtl/fetch_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit (
  input  logic             clock,
  input  logic             reset,

  // write enables from the controller
  input  logic             pc_we_i,
  input  logic             redirect_we_i,

  // pre-decode result for the held word
  input  logic             is_jal_i,
  input  fetch_pkg::addr_t jal_offset_i,

  // resolved target from the back end
  input  fetch_pkg::addr_t redirect_pc_i,

  // current fetch address
  output fetch_pkg::addr_t pc_o
);

  import fetch_pkg::*;

  addr_t pc_q;
  addr_t seq_pc;
  addr_t jal_pc;
  addr_t redirect_pc;
  addr_t pc_d;

  // --------------------------------------------------------------------------
  // candidate targets
  // --------------------------------------------------------------------------
  // pc still points at the word in flight, only one request at a time
  assign seq_pc = pc_q + PC_STEP;
  assign jal_pc = pc_q + jal_offset_i;

  // word aligned, low bits dropped
  assign redirect_pc = {redirect_pc_i[31:2], 2'b00};

  // --------------------------------------------------------------------------
  // next pc select
  // --------------------------------------------------------------------------
  always_comb begin
    pc_d = pc_q;
    // redirect and pc_we never overlap, different states
    if (redirect_we_i) begin
      pc_d = redirect_pc;
    end else if (pc_we_i) begin
      pc_d = is_jal_i ? jal_pc : seq_pc;
    end
  end

  // --------------------------------------------------------------------------
  // pc register
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // byte address of an instruction or the program counter
  typedef logic [31:0] addr_t;

  // raw 32-bit instruction word from memory
  typedef logic [31:0] inst_t;

  // pc after reset
  localparam addr_t RESET_PC = 32'h0000_1000;

  // sequential step, no compressed instructions
  localparam addr_t PC_STEP = 32'd4;

  // --------------------------------------------------------------------------
  // rv32i major opcodes seen by the pre-decoder
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;

  // --------------------------------------------------------------------------
  // fetch controller states
  // --------------------------------------------------------------------------
  // same codes as the older fetch unit, so waveforms still line up
  typedef enum logic [2:0] {
    ST_IDLE         = 3'b000,
    ST_WAIT_READY   = 3'b001,
    ST_WAIT_ARREADY = 3'b010,
    ST_WAIT_RVALID  = 3'b011,
    ST_WAIT_BRANCH  = 3'b100
  } fetch_state_e;

endpackage

`default_nettype wire

//--- rtl/fetch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predecode (
  // word held in the instruction register
  input  fetch_pkg::inst_t inst_i,

  // classification
  output logic             is_wait_branch_o,
  output logic             is_jal_o,

  // sign-extended j-type immediate
  output fetch_pkg::addr_t jal_offset_o
);

  import fetch_pkg::*;

  logic [6:0] opcode;
  addr_t      j_imm;

  // major opcode lives in the low seven bits
  assign opcode = inst_i[6:0];

  // --------------------------------------------------------------------------
  // classify
  // --------------------------------------------------------------------------
  always_comb begin
    is_wait_branch_o = 1'b0;
    is_jal_o         = 1'b0;
    case (opcode)
      // target unknown until the back end resolves it
      OPC_BRANCH: is_wait_branch_o = 1'b1;
      // register based target, also resolved later
      OPC_JALR:   is_wait_branch_o = 1'b1;
      // pc relative, target known right here
      OPC_JAL:    is_jal_o         = 1'b1;
      // anything else falls through to pc+4
      default: begin
        is_wait_branch_o = 1'b0;
        is_jal_o         = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // j-type immediate
  // --------------------------------------------------------------------------
  // imm[20|10:1|11|19:12] sits in inst[31:12]
  // bit 0 always zero, sign taken from inst[31]
  assign j_imm = {{11{inst_i[31]}},
                  inst_i[31],
                  inst_i[19:12],
                  inst_i[20],
                  inst_i[30:21],
                  1'b0};

  // only meaningful for a jal
  assign jal_offset_o = is_jal_o ? j_imm : '0;

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                    clock,
  input  logic                    reset,

  // fetch enable, sampled in idle
  input  logic                    fetch_en_i,

  // instruction memory read channel
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output fetch_pkg::addr_t        araddr_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  fetch_pkg::inst_t        rdata_i,

  // to decode
  output logic                    valid_o,
  input  logic                    ready_i,
  output fetch_pkg::inst_t        inst_o,
  output fetch_pkg::addr_t        pc_o,

  // back end redirect
  input  logic                    redirect_valid_i,
  input  fetch_pkg::addr_t        redirect_pc_i,

  // debug
  output fetch_pkg::fetch_state_e state_o
);

  import fetch_pkg::*;

  // --------------------------------------------------------------------------
  // internal nets
  // --------------------------------------------------------------------------
  // controller enables
  logic  pc_we;
  logic  redirect_we;
  logic  inst_we;

  // pre-decode results
  logic  is_wait_branch;
  logic  is_jal;
  addr_t jal_offset;

  // fetch pc and the held pair
  addr_t pc;
  inst_t inst;
  addr_t inst_pc;

  // --------------------------------------------------------------------------
  // sequencing
  // --------------------------------------------------------------------------
  fetch_controller u_controller (
    .clock            (clock),
    .reset            (reset),
    .fetch_en_i       (fetch_en_i),
    .arvalid_o        (arvalid_o),
    .arready_i        (arready_i),
    .rvalid_i         (rvalid_i),
    .rready_o         (rready_o),
    .valid_o          (valid_o),
    .ready_i          (ready_i),
    .redirect_valid_i (redirect_valid_i),
    .is_wait_branch_i (is_wait_branch),
    .pc_we_o          (pc_we),
    .redirect_we_o    (redirect_we),
    .inst_we_o        (inst_we),
    .state_o          (state_o)
  );

  // classify the held word
  fetch_predecode u_predecode (
    .inst_i           (inst),
    .is_wait_branch_o (is_wait_branch),
    .is_jal_o         (is_jal),
    .jal_offset_o     (jal_offset)
  );

  // next pc
  fetch_pc_unit u_pc_unit (
    .clock         (clock),
    .reset         (reset),
    .pc_we_i       (pc_we),
    .redirect_we_i (redirect_we),
    .is_jal_i      (is_jal),
    .jal_offset_i  (jal_offset),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  // held word and its pc
  fetch_inst_reg u_inst_reg (
    .clock     (clock),
    .reset     (reset),
    .inst_we_i (inst_we),
    .rdata_i   (rdata_i),
    .pc_i      (pc),
    .inst_o    (inst),
    .pc_o      (inst_pc)
  );

  // read address is the live pc
  assign araddr_o = pc;

  // decode sees the captured pair
  assign inst_o = inst;
  assign pc_o   = inst_pc;

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;

  localparam int          NUM_INST    = 400;
  localparam int          CLK_HALF    = 4;
  localparam int          WATCHDOG_CY = NUM_INST * 40;
  localparam logic [15:0] LFSR_SEED   = 16'd62576;
  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_TAPS   = 16'hB400;

  logic         clock;
  logic         reset;
  logic         fetch_en_i;
  logic         arvalid_o;
  logic         arready_i;
  addr_t        araddr_o;
  logic         rvalid_i;
  logic         rready_o;
  inst_t        rdata_i;
  logic         valid_o;
  logic         ready_i;
  inst_t        inst_o;
  addr_t        pc_o;
  logic         redirect_valid_i;
  addr_t        redirect_pc_i;
  fetch_state_e state_o;

  // reference model state
  logic [15:0]  lfsr;
  addr_t        exp_pc;
  logic         started;
  logic         req_pending;
  logic         waiting;
  logic [1:0]   ar_delay;
  logic [1:0]   r_delay;
  logic [1:0]   redir_delay;
  addr_t        req_addr;
  inst_t        req_word;
  addr_t        exp_addr_q[$];
  inst_t        exp_inst_q[$];
  int           delivered;
  int           addr_errs;
  int           inst_errs;
  int           state_errs;
  int           flag_errs;

  fetch_top fetch_top_inst (
    .clock            (clock),
    .reset            (reset),
    .fetch_en_i       (fetch_en_i),
    .arvalid_o        (arvalid_o),
    .arready_i        (arready_i),
    .araddr_o         (araddr_o),
    .rvalid_i         (rvalid_i),
    .rready_o         (rready_o),
    .rdata_i          (rdata_i),
    .valid_o          (valid_o),
    .ready_i          (ready_i),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .state_o          (state_o)
  );

  always #(CLK_HALF) clock = ~clock;

  // --------------------------------------------------------------------------
  // random source
  // --------------------------------------------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // n bits, one lfsr step each
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      addr_errs++;
      $display("FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      inst_errs++;
      $display("FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_state(input string name, input fetch_state_e got,
                             input fetch_state_e exp);
    if (got !== exp) begin
      state_errs++;
      $display("FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // --------------------------------------------------------------------------
  // memory and back-end models
  // --------------------------------------------------------------------------
  // class 0 plain, 1 branch, 2 jalr, 3 jal
  task automatic make_word(output inst_t w);
    logic [31:0] cls;
    logic [31:0] body;
    draw_bits(3, cls);
    draw_bits(25, body);
    w = {body[24:0], 7'b000_0000};
    case (cls[1:0])
      2'd0:    w[6:0] = cls[2] ? 7'b001_0011 : 7'b011_0011;
      2'd1:    w[6:0] = OPC_BRANCH;
      2'd2:    w[6:0] = OPC_JALR;
      default: w[6:0] = OPC_JAL;
    endcase
  endtask

  // next fetch address once a word is accepted downstream
  task automatic retire(input addr_t pc, input inst_t w);
    logic [20:0] imm;
    logic [31:0] bits;
    imm = '0;
    imm[20]    = w[31];
    imm[10:1]  = w[30:21];
    imm[11]    = w[20];
    imm[19:12] = w[19:12];
    if (w[6:0] == OPC_JAL) begin
      exp_pc = pc + {{11{imm[20]}}, imm};
    end else if (w[6:0] == OPC_BRANCH || w[6:0] == OPC_JALR) begin
      // fetch stalls until the redirect
      waiting = 1'b1;
      draw_bits(2, bits);
      redir_delay = bits[1:0];
    end else begin
      exp_pc = pc + 32'd4;
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus and checking, all on the falling edge
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] bits;
    addr_t       pop_addr;
    inst_t       pop_inst;
    clock = 1'b0;
    reset = 1'b1;
    fetch_en_i = 1'b0;
    arready_i = 1'b0;
    rvalid_i = 1'b0;
    rdata_i = '0;
    ready_i = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    lfsr = LFSR_SEED;
    exp_pc = RESET_PC;
    started = 1'b0;
    req_pending = 1'b0;
    waiting = 1'b0;
    ar_delay = 2'd0;
    r_delay = 2'd0;
    redir_delay = 2'd0;
    req_addr = '0;
    req_word = '0;
    delivered = 0;
    addr_errs = 0;
    inst_errs = 0;
    state_errs = 0;
    flag_errs = 0;
    repeat (3) @(negedge clock);
    reset = 1'b0;

    // idle with fetch disabled
    repeat (6) begin
      @(negedge clock);
      check_flag("arvalid_o", arvalid_o, 1'b0);
      check_flag("rready_o", rready_o, 1'b0);
      check_flag("valid_o", valid_o, 1'b0);
      check_state("state_o", state_o, ST_IDLE);
    end

    while (delivered < NUM_INST) begin
      @(negedge clock);
      // one thing in flight at a time
      check_flag("arvalid_o", arvalid_o,
                 started && !req_pending && exp_inst_q.size() == 0 && !waiting);
      check_flag("rready_o", rready_o, req_pending);
      check_flag("valid_o", valid_o, exp_inst_q.size() != 0);
      if (arvalid_o) begin
        check_addr("araddr_o", araddr_o, exp_pc);
      end
      if (waiting) begin
        check_state("state_o", state_o, ST_WAIT_BRANCH);
      end
      // held pair, also while stalled by ready_i
      if (valid_o && exp_inst_q.size() != 0) begin
        check_inst("inst_o", inst_o, exp_inst_q[0]);
        check_addr("pc_o", pc_o, exp_addr_q[0]);
      end

      // enable only matters in idle
      draw_bits(1, bits);
      fetch_en_i = started ? bits[0] : 1'b1;
      started = 1'b1;

      // redirect, decided on the wait flag from before this cycle
      redirect_valid_i = 1'b0;
      draw_bits(32, bits);
      redirect_pc_i = bits;
      if (waiting) begin
        if (redir_delay == 2'd0) begin
          redirect_valid_i = 1'b1;
          exp_pc = bits & 32'hFFFF_FFFC;
          waiting = 1'b0;
        end else begin
          redir_delay = redir_delay - 2'd1;
        end
      end else begin
        // stray strobe, must not move the pc
        draw_bits(3, bits);
        redirect_valid_i = (bits[2:0] == 3'd0);
      end

      // address channel
      arready_i = 1'b0;
      if (arvalid_o) begin
        if (ar_delay == 2'd0) begin
          arready_i = 1'b1;
          req_addr = exp_pc;
          make_word(req_word);
          req_pending = 1'b1;
          draw_bits(2, bits);
          ar_delay = bits[1:0];
          draw_bits(2, bits);
          r_delay = bits[1:0];
        end else begin
          ar_delay = ar_delay - 2'd1;
        end
      end

      // downstream, ready toggles with or without valid
      draw_bits(2, bits);
      ready_i = (bits[1:0] != 2'b00);
      if (valid_o && ready_i && exp_inst_q.size() != 0) begin
        pop_addr = exp_addr_q.pop_front();
        pop_inst = exp_inst_q.pop_front();
        retire(pop_addr, pop_inst);
        delivered++;
      end

      // read data channel
      rvalid_i = 1'b0;
      rdata_i = '0;
      if (rready_o && req_pending) begin
        if (r_delay == 2'd0) begin
          rvalid_i = 1'b1;
          rdata_i = req_word;
          exp_addr_q.push_back(req_addr);
          exp_inst_q.push_back(req_word);
          req_pending = 1'b0;
        end else begin
          r_delay = r_delay - 2'd1;
        end
      end
    end

    $display("errors addr %0d inst %0d state %0d flag %0d over %0d instructions",
             addr_errs, inst_errs, state_errs, flag_errs, delivered);
    if (addr_errs + inst_errs + state_errs + flag_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // hang guard, about 40 cycles per instruction
  initial begin
    repeat (WATCHDOG_CY) @(posedge clock);
    $display("timeout after %0d cycles, only %0d instructions delivered",
             WATCHDOG_CY, delivered);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/fetch_pkg.sv
rtl/fetch_predecode.sv
rtl/fetch_controller.sv
rtl/fetch_pc_unit.sv
rtl/fetch_inst_reg.sv
rtl/fetch_top.sv
verif/fetch_tb.sv
